//--- vlog.f
mipsPkg.sv
ctrlIf.sv
mainDecoder.sv
alu.sv
regFile.sv
pcUnit.sv
dataPath.sv
singleCycleMips.sv
singleCycleMips_assert.sv
mipsChecker.sv
tbMips.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
  --top-module tbMips -f vlog.f -o simMips

./obj_dir/simMips +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run.sh: simulation reported failure"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run.sh: simulation ended without a result"
  exit 1
fi
exit 0

//--- tbMips.sv
// testbench top with clock, reset, program ROM, data memory model, DUT, checker and run control
module tbMips;

  timeunit 1ns;
  timeprecision 100ps;

  import mipsPkg::*;

  // ====================================================================
  // sizes and limits
  // ====================================================================
  localparam int addrBits = 7;
  localparam int memWords = 1 << addrBits;
  localparam int romWords = 64;
  localparam int romBits = $clog2(romWords);
  localparam int programWords = 40;
  // five cycles per program word
  localparam int cycleLimit = 5 * programWords;
  localparam logic [31:0] haltAddr = 32'((programWords - 1) * 4);

  logic                clk = 1'b0;
  logic                rst = 1'b0;
  logic [31:0]         ir;
  logic [31:0]         irAddr;
  logic [31:0]         rfWriteData;
  logic [31:0]         readDataMem;
  logic                cen;
  logic                wen;
  logic                oen;
  logic [addrBits-1:0] a;
  logic [31:0]         writeData;

  logic [31:0] rom [romWords];
  logic [31:0] initMem [memWords];
  logic [31:0] dataMem [memWords];

  logic done;
  int   mismatches;
  int   cycles = 0;
  int   timeouts = 0;

  // 40 ns period
  always #20 clk = ~clk;

  // ====================================================================
  // instruction encoders
  // ====================================================================
  // add rd, rs, rt style argument order
  function automatic logic [31:0] rWord(input functT fn, input int rd, input int rs, input int rt);
    return {rType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic logic [31:0] iWord(input opcodeT op, input int rs, input int rt,
                                        input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] jWord(input opcodeT op, input int target);
    return {op, target[25:0]};
  endfunction

  // 32-bit xorshift step
  function automatic logic [31:0] nextRandom(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ====================================================================
  // test program, word index in the ROM
  // ====================================================================
  task automatic loadProgram();
    // random operands from words 0..2
    rom[0]  = iWord(lw, 0, 1, 0);
    rom[1]  = iWord(lw, 0, 2, 4);
    rom[2]  = iWord(lw, 0, 3, 8);
    // alu ops and signed slt against the negative difference in r5
    rom[3]  = rWord(add, 4, 1, 2);
    rom[4]  = rWord(sub, 5, 1, 2);
    rom[5]  = rWord(andOp, 6, 1, 3);
    rom[6]  = rWord(orOp, 7, 2, 3);
    rom[7]  = rWord(slt, 8, 1, 5);
    rom[8]  = rWord(slt, 9, 5, 1);
    // write to r0, then read it back
    rom[9]  = rWord(add, 0, 1, 2);
    rom[10] = rWord(orOp, 10, 0, 1);
    // store, reload, compare
    rom[11] = iWord(sw, 0, 4, 64);
    rom[12] = iWord(sw, 0, 5, 68);
    rom[13] = iWord(lw, 0, 11, 64);
    rom[14] = iWord(lw, 0, 12, 68);
    rom[15] = rWord(sub, 13, 11, 4);
    // forward taken to 19
    rom[16] = iWord(beq, 13, 0, 2);
    rom[17] = rWord(add, 14, 1, 1);
    rom[18] = rWord(add, 14, 2, 2);
    // not taken
    rom[19] = iWord(beq, 1, 2, 5);
    rom[20] = iWord(sw, 0, 8, 72);
    // backward branch taken once
    rom[21] = rWord(add, 18, 0, 0);
    rom[22] = rWord(add, 18, 18, 1);
    rom[23] = iWord(beq, 18, 1, -2);
    // call at 28 links pc+8, so return lands on 26
    rom[24] = jWord(jal, 28);
    rom[25] = rWord(add, 19, 1, 1);
    rom[26] = iWord(sw, 0, 31, 76);
    rom[27] = jWord(j, 32);
    rom[28] = rWord(add, 20, 31, 0);
    rom[29] = iWord(sw, 0, 20, 80);
    rom[30] = rWord(jr, 0, 31, 0);
    rom[31] = rWord(add, 21, 1, 1);
    rom[32] = iWord(lw, 0, 22, 76);
    rom[33] = iWord(lw, 0, 23, 80);
    rom[34] = rWord(slt, 24, 22, 23);
    rom[35] = iWord(beq, 0, 0, 1);
    rom[36] = rWord(sub, 25, 1, 2);
    rom[37] = iWord(lw, 0, 26, 72);
    rom[38] = rWord(andOp, 27, 26, 8);
    // halt by jumping to itself
    rom[39] = jWord(j, 39);
  endtask

  // ====================================================================
  // memory models
  // ====================================================================
  assign ir = rom[irAddr[romBits+1:2]];
  assign readDataMem = dataMem[a];

  // reloaded in reset, clocked write when cen and wen are low
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < memWords; i++) begin
        dataMem[i] <= initMem[i];
      end
    end else if (!cen && !wen) begin
      dataMem[a] <= writeData;
    end
  end

  singleCycleMips #(
    .dataAddrBits (addrBits)
  ) singleCycleMips_inst (
    .clk         (clk),
    .rst         (rst),
    .ir          (ir),
    .irAddr      (irAddr),
    .rfWriteData (rfWriteData),
    .readDataMem (readDataMem),
    .cen         (cen),
    .wen         (wen),
    .oen         (oen),
    .a           (a),
    .writeData   (writeData)
  );

  mipsChecker #(
    .addrBits (addrBits),
    .romWords (romWords),
    .haltAddr (haltAddr)
  ) mipsChecker_inst (
    .clk         (clk),
    .rst         (rst),
    .rom         (rom),
    .initMem     (initMem),
    .irAddr      (irAddr),
    .rfWriteData (rfWriteData),
    .cen         (cen),
    .wen         (wen),
    .oen         (oen),
    .a           (a),
    .writeData   (writeData),
    .done        (done),
    .errorCount  (mismatches)
  );

  // ====================================================================
  // run control
  // ====================================================================
  initial begin
    logic [31:0] seed;
    seed = 32'd37;
    for (int i = 0; i < memWords; i++) begin
      seed = nextRandom(seed);
      initMem[i] = seed;
    end
    for (int i = 0; i < romWords; i++) begin
      rom[i] = 32'd0;
    end
    loadProgram();
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    // sample at the falling edge where outputs are settled
    while (!done && cycles < cycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (done) begin
      // one more edge for the halt address check
      @(posedge clk);
      @(negedge clk);
    end else begin
      $display("ERROR timeout, halt address not reached within %0d cycles", cycleLimit);
      timeouts++;
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- mipsChecker.sv
// reference model of the core and per-cycle comparison against the DUT ports
module mipsChecker #(
  parameter int          addrBits = 7,
  parameter int          romWords = 64,
  parameter logic [31:0] haltAddr = 32'd0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         rom [romWords],
  input  logic [31:0]         initMem [1 << addrBits],
  input  logic [31:0]         irAddr,
  input  logic [31:0]         rfWriteData,
  input  logic                cen,
  input  logic                wen,
  input  logic                oen,
  input  logic [addrBits-1:0] a,
  input  logic [31:0]         writeData,
  output logic                done,
  output int                  errorCount
);

  timeunit 1ns;
  timeprecision 100ps;

  import mipsPkg::*;

  localparam int memWords = 1 << addrBits;
  localparam int romBits = $clog2(romWords);

  // model state
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [memWords];
  logic [31:0] modelPc;
  logic        halted = 1'b0;
  int          errors = 0;
  string       testName = "reset";

  // expected port values of the instruction just run
  logic                expWrite;
  logic [31:0]         expValue;
  logic                expCen;
  logic                expWen;
  logic [addrBits-1:0] expAddr;
  logic [31:0]         expStore;

  assign done = halted;
  assign errorCount = errors;

  task automatic checkValue(input string signal, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s expected %h actual %h", testName, signal, expected, actual);
      errors++;
    end
  endtask

  // ====================================================================
  // one instruction on the model
  // ====================================================================
  function automatic void executeOne(input logic [31:0] word);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  destReg;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] pcNext;
    op = word[31:26];
    fn = word[5:0];
    rs = word[25:21];
    rt = word[20:16];
    va = modelRegs[rs];
    vb = modelRegs[rt];
    imm = {{16{word[15]}}, word[15:0]};
    addr = va + imm;
    pcNext = modelPc + 32'd4;
    destReg = word[15:11];
    expWrite = 1'b0;
    expValue = 32'd0;
    expCen = 1'b1;
    expWen = 1'b1;
    expAddr = addr[addrBits+1:2];
    expStore = vb;
    case (op)
      rType: begin
        testName = "alu";
        expWrite = 1'b1;
        case (fn)
          add:   expValue = va + vb;
          sub:   expValue = va - vb;
          andOp: expValue = va & vb;
          orOp:  expValue = va | vb;
          // signed compare
          slt:   expValue = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
          jr: begin
            testName = "jr";
            expWrite = 1'b0;
            pcNext = va;
          end
          default: expWrite = 1'b0;
        endcase
      end
      lw: begin
        testName = "load";
        expCen = 1'b0;
        expWrite = 1'b1;
        destReg = rt;
        expValue = modelMem[expAddr];
      end
      sw: begin
        testName = "store";
        expCen = 1'b0;
        expWen = 1'b0;
        modelMem[expAddr] = vb;
      end
      beq: begin
        if (va == vb) begin
          testName = "beq taken";
          pcNext = pcNext + {imm[29:0], 2'b00};
        end else begin
          testName = "beq not taken";
        end
      end
      j: begin
        testName = "j";
        pcNext = {pcNext[31:28], word[25:0], 2'b00};
      end
      jal: begin
        testName = "jal";
        // links pc+8
        expWrite = 1'b1;
        destReg = linkReg;
        expValue = modelPc + 32'd8;
        pcNext = {pcNext[31:28], word[25:0], 2'b00};
      end
      default: testName = "nop";
    endcase
    // r0 stays zero
    if (expWrite && destReg != 5'd0) begin
      modelRegs[destReg] = expValue;
    end
    modelPc = pcNext;
  endfunction

  // ====================================================================
  // compare on every rising edge
  // ====================================================================
  always @(posedge clk) begin
    if (!rst) begin
      checkValue("cen", 32'd1, 32'(cen));
      checkValue("wen", 32'd1, 32'(wen));
      modelPc = 32'd0;
      for (int i = 0; i < 32; i++) begin
        modelRegs[i] = 32'd0;
      end
      for (int i = 0; i < memWords; i++) begin
        modelMem[i] = initMem[i];
      end
    end else if (!halted) begin
      // next pc follows from the previous instruction
      checkValue("irAddr", modelPc, irAddr);
      executeOne(rom[modelPc[romBits+1:2]]);
      if (expWrite) begin
        checkValue("rfWriteData", expValue, rfWriteData);
      end
      checkValue("cen", 32'(expCen), 32'(cen));
      checkValue("wen", 32'(expWen), 32'(wen));
      // output enable always active low
      checkValue("oen", 32'd0, 32'(oen));
      if (!expCen) begin
        checkValue("a", 32'(expAddr), 32'(a));
      end
      if (!expWen) begin
        checkValue("writeData", expStore, writeData);
      end
      if (modelPc == haltAddr) begin
        halted = 1'b1;
      end
    end else begin
      testName = "halt";
      checkValue("irAddr", haltAddr, irAddr);
    end
  end

endmodule

//--- singleCycleMips_assert.sv
// concurrent assertions on the memory strobes and fetch address, bound into the core top
module singleCycleMipsAssert (
  input logic        clk,
  input logic        rst,
  input logic        cen,
  input logic        wen,
  input logic [31:0] irAddr
);

  timeunit 1ns;
  timeprecision 100ps;

  // a write is always a chip access
  writeNeedsEnable: assert property (@(posedge clk) !wen |-> !cen)
    else $error("wen low while cen high");

  // fetch on a word boundary
  fetchAligned: assert property (@(posedge clk) disable iff (!rst) irAddr[1:0] == 2'b00)
    else $error("irAddr not word aligned");

  // no memory access while held in reset
  quietInReset: assert property (@(posedge clk) !rst |-> (wen && cen))
    else $error("memory strobe active during reset");

endmodule

bind singleCycleMips singleCycleMipsAssert singleCycleMipsAssert_inst (
  .clk    (clk),
  .rst    (rst),
  .cen    (cen),
  .wen    (wen),
  .irAddr (irAddr)
);

//--- singleCycleMips.sv
// single-cycle core top, decoder, program counter and datapath on plain memory ports
module singleCycleMips #(
  parameter int dataAddrBits = 7
) (
  input  logic                    clk,
  input  logic                    rst,
  // instruction memory
  input  logic [31:0]             ir,
  output logic [31:0]             irAddr,
  // write-back value, visible for checking
  output logic [31:0]             rfWriteData,
  // data memory
  input  logic [31:0]             readDataMem,
  output logic                    cen,
  output logic                    wen,
  output logic                    oen,
  output logic [dataAddrBits-1:0] a,
  output logic [31:0]             writeData
);

  // ====================================================================
  // internal nets
  // ====================================================================
  logic        branchTaken;
  logic [31:0] jumpReg;
  logic [31:0] pcLink;

  // decoded control levels
  ctrlIf ctl ();

  mainDecoder mainDecoder_inst (
    .ir  (ir),
    .ctl (ctl)
  );

  // irAddr straight from the counter register
  pcUnit pcUnit_inst (
    .clk         (clk),
    .rst         (rst),
    .ctl         (ctl),
    .ir          (ir),
    .branchTaken (branchTaken),
    .jumpReg     (jumpReg),
    .pcValue     (irAddr),
    .pcLink      (pcLink)
  );

  dataPath #(
    .dataAddrBits (dataAddrBits)
  ) dataPath_inst (
    .clk         (clk),
    .rst         (rst),
    .ctl         (ctl),
    .ir          (ir),
    .readDataMem (readDataMem),
    .pcLink      (pcLink),
    .branchTaken (branchTaken),
    .jumpReg     (jumpReg),
    .rfWriteData (rfWriteData),
    .cen         (cen),
    .wen         (wen),
    .oen         (oen),
    .a           (a),
    .writeData   (writeData)
  );

endmodule

//--- dataPath.sv
// datapath with operand and write-back selection, register file, ALU and data memory strobes
module dataPath #(
  parameter int dataAddrBits = 7
) (
  input  logic                    clk,
  input  logic                    rst,
  ctrlIf.dp                       ctl,
  input  mipsPkg::instrWordT      ir,
  input  logic [31:0]             readDataMem,
  input  logic [31:0]             pcLink,
  output logic                    branchTaken,
  output logic [31:0]             jumpReg,
  output logic [31:0]             rfWriteData,
  output logic                    cen,
  output logic                    wen,
  output logic                    oen,
  output logic [dataAddrBits-1:0] a,
  output logic [31:0]             writeData
);

  import mipsPkg::*;

  logic [31:0] signExt;
  logic [31:0] readA;
  logic [31:0] readB;
  logic [31:0] opB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [4:0]  writeAddr;

  // ====================================================================
  // operands
  // ====================================================================
  assign signExt = {{16{ir.iFields.imm16[15]}}, ir.iFields.imm16};

  // immediate for lw and sw, rt otherwise
  assign opB = ctl.aluSrc ? signExt : readB;

  // ====================================================================
  // write-back selection
  // ====================================================================
  // jal overrides to r31
  assign writeAddr = ctl.link   ? linkReg :
                     ctl.regDst ? ir.rFields.rd : ir.rFields.rt;

  assign rfWriteData = ctl.link     ? pcLink :
                       ctl.memToReg ? readDataMem : aluResult;

  regFile regFile_inst (
    .clk        (clk),
    .rst        (rst),
    .writeEn    (ctl.regWrite),
    .readAddrA  (ir.rFields.rs),
    .readAddrB  (ir.rFields.rt),
    .writeAddr  (writeAddr),
    .writeValue (rfWriteData),
    .readValueA (readA),
    .readValueB (readB)
  );

  alu alu_inst (
    .opA    (readA),
    .opB    (opB),
    .aluOp  (ctl.aluOp),
    .funct  (ir.rFields.funct),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ====================================================================
  // control flow and memory port
  // ====================================================================
  assign branchTaken = ctl.branch & aluZero;

  // rs value for jr
  assign jumpReg = readA;

  // store data is rt
  assign writeData = readB;

  // word address from the byte address
  assign a = aluResult[dataAddrBits+1:2];

  // strobes active low, held inactive in reset
  // chip enable only for lw and sw
  assign cen = ~rst | ~(ctl.memToReg | ctl.memWrite);
  assign wen = ~rst | ~ctl.memWrite;
  assign oen = 1'b0;

endmodule

//--- pcUnit.sv
// program counter register with sequential, branch, jump and register-jump selection
module pcUnit (
  input  logic               clk,
  input  logic               rst,
  ctrlIf.pc                  ctl,
  input  mipsPkg::instrWordT ir,
  input  logic               branchTaken,
  input  logic [31:0]        jumpReg,
  output logic [31:0]        pcValue,
  output logic [31:0]        pcLink
);

  logic [31:0] pcPlus4;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  // ====================================================================
  // candidate addresses
  // ====================================================================
  assign pcPlus4 = pcValue + 32'd4;

  // offset is in words, sign extended then scaled by four
  assign branchTarget = pcPlus4 + {{14{ir.iFields.imm16[15]}}, ir.iFields.imm16, 2'b00};

  // region bits from pc+4, target fills the rest
  assign jumpTarget = {pcPlus4[31:28], ir.jFields.target26, 2'b00};

  // return address for jal
  assign pcLink = pcValue + 32'd8;

  // ====================================================================
  // next address, jump first, then taken branch, then jr
  // ====================================================================
  always_comb begin
    if (ctl.jump) begin
      nextPc = jumpTarget;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else if (ctl.regJump) begin
      // value of rs, not the field
      nextPc = jumpReg;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // counter register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcValue <= 32'd0;
    end else begin
      pcValue <= nextPc;
    end
  end

endmodule

//--- regFile.sv
// 32 x 32 register file, two combinational reads, one clocked write
module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        writeEn,
  input  logic [4:0]  readAddrA,
  input  logic [4:0]  readAddrB,
  input  logic [4:0]  writeAddr,
  input  logic [31:0] writeValue,
  output logic [31:0] readValueA,
  output logic [31:0] readValueB
);

  // architectural registers
  logic [31:0] regs [32];

  // ====================================================================
  // write port
  // ====================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // whole file cleared
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      // r0 never written
      regs[writeAddr] <= writeValue;
    end
  end

  // ====================================================================
  // read ports
  // ====================================================================
  // r0 forced to zero on both ports
  assign readValueA = (readAddrA == 5'd0) ? 32'd0 : regs[readAddrA];
  assign readValueB = (readAddrB == 5'd0) ? 32'd0 : regs[readAddrB];

endmodule

//--- alu.sv
// ALU with local function decode, 32-bit result and zero flag
module alu (
  input  logic [31:0]    opA,
  input  logic [31:0]    opB,
  input  mipsPkg::aluOpT aluOp,
  input  mipsPkg::functT funct,
  output logic [31:0]    result,
  output logic           zero
);

  import mipsPkg::*;

  // internal operation select
  localparam logic [2:0] opAdd  = 3'd0;
  localparam logic [2:0] opSub  = 3'd1;
  localparam logic [2:0] opAnd  = 3'd2;
  localparam logic [2:0] opOr   = 3'd3;
  localparam logic [2:0] opSlt  = 3'd4;
  localparam logic [2:0] opNone = 3'd5;

  logic [2:0] opSel;

  // ====================================================================
  // request plus funct to one operation
  // ====================================================================
  always_comb begin
    case (aluOp)
      memAdd:    opSel = opAdd;
      branchSub: opSel = opSub;
      useFunct: begin
        case (funct)
          add:     opSel = opAdd;
          sub:     opSel = opSub;
          andOp:   opSel = opAnd;
          orOp:    opSel = opOr;
          slt:     opSel = opSlt;
          // jr and anything unknown
          default: opSel = opNone;
        endcase
      end
      default:   opSel = opNone;
    endcase
  end

  // ====================================================================
  // datapath
  // ====================================================================
  always_comb begin
    case (opSel)
      opAdd:   result = opA + opB;
      opSub:   result = opA - opB;
      opAnd:   result = opA & opB;
      opOr:    result = opA | opB;
      // two's complement compare
      opSlt:   result = {31'd0, $signed(opA) < $signed(opB)};
      default: result = 32'd0;
    endcase
  end

  // any zero result, beq reads it after a subtract
  assign zero = (result == 32'd0);

endmodule

//--- mainDecoder.sv
// opcode and function decoder producing the control bundle
module mainDecoder (
  input  mipsPkg::instrWordT ir,
  ctrlIf.dec                 ctl
);

  import mipsPkg::*;

  // ====================================================================
  // control levels for the current instruction
  // ====================================================================
  always_comb begin
    // all inactive, unknown words fall through as a nop
    ctl.regDst   = 1'b0;
    ctl.aluSrc   = 1'b0;
    ctl.memToReg = 1'b0;
    ctl.regWrite = 1'b0;
    ctl.memWrite = 1'b0;
    ctl.branch   = 1'b0;
    ctl.jump     = 1'b0;
    ctl.link     = 1'b0;
    ctl.regJump  = 1'b0;
    ctl.aluOp    = memAdd;

    case (ir.rFields.opcode)
      rType: begin
        // funct picks the operation
        case (ir.rFields.funct)
          add, sub, andOp, orOp, slt: begin
            ctl.regDst   = 1'b1;
            ctl.regWrite = 1'b1;
            ctl.aluOp    = useFunct;
          end
          // jr, no write-back
          jr: ctl.regJump = 1'b1;
          default: ;
        endcase
      end
      lw: begin
        // base + offset, loaded word to rt
        ctl.aluSrc   = 1'b1;
        ctl.memToReg = 1'b1;
        ctl.regWrite = 1'b1;
      end
      sw: begin
        ctl.aluSrc   = 1'b1;
        ctl.memWrite = 1'b1;
      end
      beq: begin
        // subtract rs - rt, zero flag decides
        ctl.branch = 1'b1;
        ctl.aluOp  = branchSub;
      end
      j: ctl.jump = 1'b1;
      jal: begin
        ctl.jump     = 1'b1;
        ctl.link     = 1'b1;
        ctl.regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- ctrlIf.sv
// control bundle interface from the decoder to the datapath and program counter
interface ctrlIf;

  // destination and second operand selection
  logic regDst;
  logic aluSrc;

  // write-back and data memory
  logic memToReg;
  logic regWrite;
  logic memWrite;

  // control flow
  logic branch;
  logic jump;
  // jal, also selects r31 and pc+8 for write-back
  logic link;
  // jr, next pc from register rs
  logic regJump;

  mipsPkg::aluOpT aluOp;

  // decoder drives every level
  modport dec (output regDst, aluSrc, memToReg, regWrite, memWrite,
               branch, jump, link, regJump, aluOp);

  // datapath side
  modport dp (input regDst, aluSrc, memToReg, regWrite, memWrite,
              branch, link, aluOp);

  // program counter only needs the jump kinds
  modport pc (input jump, regJump);

endinterface

//--- mipsPkg.sv
// opcode, function and ALU request encodings, instruction word union, link register index
package mipsPkg;

  // ====================================================================
  // primary opcodes, bits 31:26
  // ====================================================================
  typedef enum logic [5:0] {
    rType = 6'b000000,
    j     = 6'b000010,
    jal   = 6'b000011,
    beq   = 6'b000100,
    lw    = 6'b100011,
    sw    = 6'b101011
  } opcodeT;

  // ====================================================================
  // function field of R-type words, bits 5:0
  // ====================================================================
  typedef enum logic [5:0] {
    jr    = 6'b001000,
    add   = 6'b100000,
    sub   = 6'b100010,
    andOp = 6'b100100,
    orOp  = 6'b100101,
    slt   = 6'b101010
  } functT;

  // decoder request to the ALU
  // memAdd for address forming, branchSub for beq compare
  typedef enum logic [1:0] {
    memAdd    = 2'b00,
    branchSub = 2'b01,
    useFunct  = 2'b10
  } aluOpT;

  // ====================================================================
  // instruction word, one 32-bit word seen in three formats
  // ====================================================================
  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    // shift amount, not used by this subset
    logic [4:0]  shamt;
    functT       funct;
  } rFieldsT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    // signed offset for lw, sw and beq
    logic [15:0] imm16;
  } iFieldsT;

  typedef struct packed {
    opcodeT      opcode;
    logic [25:0] target26;
  } jFieldsT;

  typedef union packed {
    rFieldsT rFields;
    iFieldsT iFields;
    jFieldsT jFields;
  } instrWordT;

  // jal return address goes here
  localparam logic [4:0] linkReg = 5'd31;

endpackage
